// File: hdl/nes_clk_pkg.sv
package nes_clk_pkg;

    // widths
    typedef logic [1:0]  cpu_phase_t;   // slot in the 3-cycle cpu period
    typedef logic [2:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [13:0] vram_addr_t;
    typedef logic [8:0]  dot_t;
    typedef logic [8:0]  scanline_t;

    // shared first/second write toggle for scroll and address
    typedef enum logic {
        latch_first,
        latch_second
    } write_latch_t;

    // clocking
    localparam int CPU_DIV        = 3;
    localparam int RST_CPU_CYCLES = 8;

    // frame geometry
    localparam int DOTS_PER_LINE   = 341;
    localparam int LINES_PER_FRAME = 262;
    localparam int VBLANK_LINE     = 241;
    localparam int PRERENDER_LINE  = 261;
    localparam int VBLANK_DOT      = 1;

    // write buffer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // register select
    localparam reg_addr_t REG_CTRL    = 3'd0;
    localparam reg_addr_t REG_MASK    = 3'd1;
    localparam reg_addr_t REG_OAMADDR = 3'd3;
    localparam reg_addr_t REG_SCROLL  = 3'd5;
    localparam reg_addr_t REG_ADDR    = 3'd6;

endpackage

// File: hdl/clock_enables.sv
module clock_enables (
    input  logic                    clk_ppu,
    input  logic                    rst_ppu,
    output nes_clk_pkg::cpu_phase_t cpu_phase,
    output logic                    cpu_en,
    output logic                    rst_cpu
);

    localparam nes_clk_pkg::cpu_phase_t PHASE_LAST =
        nes_clk_pkg::cpu_phase_t'(nes_clk_pkg::CPU_DIV - 1);

    nes_clk_pkg::cpu_phase_t phase_q;
    logic [nes_clk_pkg::RST_CPU_CYCLES-1:0] rst_sr;

    // divide by three, cpu edge on the last phase
    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            phase_q <= '0;
        end else if (phase_q == PHASE_LAST) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 2'd1;
        end
    end

    assign cpu_phase = phase_q;
    assign cpu_en    = (phase_q == PHASE_LAST);

    // cpu reset trails ppu reset by RST_CPU_CYCLES edges
    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            rst_sr <= '1;
        end else begin
            rst_sr <= {rst_sr[nes_clk_pkg::RST_CPU_CYCLES-2:0], 1'b0}; // zeros in
        end
    end

    assign rst_cpu = rst_sr[nes_clk_pkg::RST_CPU_CYCLES-1];

endmodule

// File: hdl/ppu_timing.sv
module ppu_timing (
    input  logic                   clk_ppu,
    input  logic                   rst_ppu,
    output nes_clk_pkg::dot_t      dot,
    output nes_clk_pkg::scanline_t scanline,
    output logic                   vblank
);

    localparam nes_clk_pkg::dot_t LAST_DOT =
        nes_clk_pkg::dot_t'(nes_clk_pkg::DOTS_PER_LINE - 1);
    localparam nes_clk_pkg::scanline_t LAST_LINE =
        nes_clk_pkg::scanline_t'(nes_clk_pkg::LINES_PER_FRAME - 1);
    localparam nes_clk_pkg::dot_t FLAG_DOT =
        nes_clk_pkg::dot_t'(nes_clk_pkg::VBLANK_DOT);
    localparam nes_clk_pkg::scanline_t SET_LINE =
        nes_clk_pkg::scanline_t'(nes_clk_pkg::VBLANK_LINE);
    localparam nes_clk_pkg::scanline_t CLR_LINE =
        nes_clk_pkg::scanline_t'(nes_clk_pkg::PRERENDER_LINE);

    nes_clk_pkg::dot_t      dot_nxt;
    nes_clk_pkg::scanline_t line_nxt;
    logic                   set_vbl;
    logic                   clr_vbl;

    always_comb begin
        dot_nxt  = dot + 9'd1;
        line_nxt = scanline;
        if (dot == LAST_DOT) begin
            dot_nxt  = '0;
            line_nxt = (scanline == LAST_LINE) ? '0 : scanline + 9'd1;
        end
    end

    // flag changes on the edge that lands on the named position
    assign set_vbl = (dot_nxt == FLAG_DOT) && (line_nxt == SET_LINE);
    assign clr_vbl = (dot_nxt == FLAG_DOT) && (line_nxt == CLR_LINE);

    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            dot      <= '0;
            scanline <= '0;
        end else begin
            dot      <= dot_nxt;
            scanline <= line_nxt;
        end
    end

    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            vblank <= 1'b0;
        end else if (set_vbl) begin
            vblank <= 1'b1;
        end else if (clr_vbl) begin
            vblank <= 1'b0;
        end
    end

endmodule

// File: hdl/cpu_write_port.sv
module cpu_write_port (
    input  logic                   clk_ppu,
    input  logic                   rst_ppu,
    input  logic                   cpu_en,
    input  logic                   rst_cpu,
    input  logic                   cpu_wr,
    input  nes_clk_pkg::reg_addr_t cpu_addr,
    input  nes_clk_pkg::reg_data_t cpu_wdata,
    output logic                   push,
    output nes_clk_pkg::reg_addr_t push_addr,
    output nes_clk_pkg::reg_data_t push_data
);

    logic accept;

    // bus is only valid on the cpu edge, and only once the cpu runs
    assign accept = cpu_wr && cpu_en && !rst_cpu;

    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            push <= 1'b0;
        end else begin
            push <= accept; // single cycle, cpu_en never repeats back to back
        end
    end

    always_ff @(posedge clk_ppu) begin
        if (accept) begin
            push_addr <= cpu_addr;
            push_data <= cpu_wdata;
        end
    end

endmodule

// File: hdl/reg_write_fifo.sv
module reg_write_fifo (
    input  logic                   clk_ppu,
    input  logic                   rst_ppu,
    input  logic                   push,
    input  nes_clk_pkg::reg_addr_t push_addr,
    input  nes_clk_pkg::reg_data_t push_data,
    input  logic                   pop,
    output logic                   not_empty,
    output logic                   full,
    output nes_clk_pkg::reg_addr_t head_addr,
    output nes_clk_pkg::reg_data_t head_data
);

    localparam int PW = nes_clk_pkg::FIFO_PTR_W;
    localparam logic [PW-1:0] PTR_LAST = PW'(nes_clk_pkg::FIFO_DEPTH - 1);
    localparam logic [PW:0]   CNT_FULL = (PW + 1)'(nes_clk_pkg::FIFO_DEPTH);

    nes_clk_pkg::reg_addr_t addr_mem [nes_clk_pkg::FIFO_DEPTH];
    nes_clk_pkg::reg_data_t data_mem [nes_clk_pkg::FIFO_DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;   // one bit wider than the pointers

    always_ff @(posedge clk_ppu) begin
        if (push) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign not_empty = (count != '0);
    assign full      = (count == CNT_FULL);
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

endmodule

// File: hdl/ppu_reg_file.sv
module ppu_reg_file (
    input  logic                    clk_ppu,
    input  logic                    rst_ppu,
    input  logic                    not_empty,
    input  nes_clk_pkg::reg_addr_t  head_addr,
    input  nes_clk_pkg::reg_data_t  head_data,
    input  logic                    vblank,
    output logic                    pop,
    output nes_clk_pkg::reg_data_t  ppu_ctrl,
    output nes_clk_pkg::reg_data_t  ppu_mask,
    output nes_clk_pkg::reg_data_t  oam_addr,
    output nes_clk_pkg::reg_data_t  scroll_x,
    output nes_clk_pkg::reg_data_t  scroll_y,
    output nes_clk_pkg::vram_addr_t vram_addr,
    output logic                    nmi
);

    nes_clk_pkg::write_latch_t latch;

    // drain one entry per cycle
    assign pop = not_empty;

    always_ff @(posedge clk_ppu) begin
        if (rst_ppu) begin
            ppu_ctrl  <= '0;
            ppu_mask  <= '0;
            oam_addr  <= '0;
            scroll_x  <= '0;
            scroll_y  <= '0;
            vram_addr <= '0;
            latch     <= nes_clk_pkg::latch_first;
        end else if (pop) begin
            case (head_addr)
                nes_clk_pkg::REG_CTRL: begin
                    ppu_ctrl <= head_data;
                end
                nes_clk_pkg::REG_MASK: begin
                    ppu_mask <= head_data;
                end
                nes_clk_pkg::REG_OAMADDR: begin
                    oam_addr <= head_data;
                end
                nes_clk_pkg::REG_SCROLL: begin
                    if (latch == nes_clk_pkg::latch_first) begin
                        scroll_x <= head_data;
                        latch    <= nes_clk_pkg::latch_second;
                    end else begin
                        scroll_y <= head_data;
                        latch    <= nes_clk_pkg::latch_first;
                    end
                end
                nes_clk_pkg::REG_ADDR: begin
                    if (latch == nes_clk_pkg::latch_first) begin
                        vram_addr[13:8] <= head_data[5:0]; // top two data bits dropped
                        latch           <= nes_clk_pkg::latch_second;
                    end else begin
                        vram_addr[7:0] <= head_data;
                        latch          <= nes_clk_pkg::latch_first;
                    end
                end
                default: begin
                    // unmodeled registers, latch untouched
                end
            endcase
        end
    end

    // level, so enabling nmi inside vblank fires right away
    assign nmi = vblank & ppu_ctrl[7];

endmodule

// File: hdl/nes_clk_top.sv
module nes_clk_top (
    input  logic                    clk_ppu,
    input  logic                    rst_ppu,
    input  logic                    cpu_wr,
    input  nes_clk_pkg::reg_addr_t  cpu_addr,
    input  nes_clk_pkg::reg_data_t  cpu_wdata,
    output nes_clk_pkg::cpu_phase_t cpu_phase,
    output logic                    cpu_en,
    output logic                    rst_cpu,
    output nes_clk_pkg::dot_t       dot,
    output nes_clk_pkg::scanline_t  scanline,
    output logic                    vblank,
    output logic                    full,
    output nes_clk_pkg::reg_data_t  ppu_ctrl,
    output nes_clk_pkg::reg_data_t  ppu_mask,
    output nes_clk_pkg::reg_data_t  oam_addr,
    output nes_clk_pkg::reg_data_t  scroll_x,
    output nes_clk_pkg::reg_data_t  scroll_y,
    output nes_clk_pkg::vram_addr_t vram_addr,
    output logic                    nmi
);

    logic                   push;
    nes_clk_pkg::reg_addr_t push_addr;
    nes_clk_pkg::reg_data_t push_data;
    logic                   pop;
    logic                   not_empty;
    nes_clk_pkg::reg_addr_t head_addr;
    nes_clk_pkg::reg_data_t head_data;

    clock_enables u_clock_enables (
        .clk_ppu   (clk_ppu),
        .rst_ppu   (rst_ppu),
        .cpu_phase (cpu_phase),
        .cpu_en    (cpu_en),
        .rst_cpu   (rst_cpu)
    );

    ppu_timing u_ppu_timing (
        .clk_ppu  (clk_ppu),
        .rst_ppu  (rst_ppu),
        .dot      (dot),
        .scanline (scanline),
        .vblank   (vblank)
    );

    cpu_write_port u_cpu_write_port (
        .clk_ppu   (clk_ppu),
        .rst_ppu   (rst_ppu),
        .cpu_en    (cpu_en),
        .rst_cpu   (rst_cpu),
        .cpu_wr    (cpu_wr),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .push      (push),
        .push_addr (push_addr),
        .push_data (push_data)
    );

    reg_write_fifo u_reg_write_fifo (
        .clk_ppu   (clk_ppu),
        .rst_ppu   (rst_ppu),
        .push      (push),
        .push_addr (push_addr),
        .push_data (push_data),
        .pop       (pop),
        .not_empty (not_empty),
        .full      (full),
        .head_addr (head_addr),
        .head_data (head_data)
    );

    ppu_reg_file u_ppu_reg_file (
        .clk_ppu   (clk_ppu),
        .rst_ppu   (rst_ppu),
        .not_empty (not_empty),
        .head_addr (head_addr),
        .head_data (head_data),
        .vblank    (vblank),
        .pop       (pop),
        .ppu_ctrl  (ppu_ctrl),
        .ppu_mask  (ppu_mask),
        .oam_addr  (oam_addr),
        .scroll_x  (scroll_x),
        .scroll_y  (scroll_y),
        .vram_addr (vram_addr),
        .nmi       (nmi)
    );

endmodule

// File: dv/nes_clk_chk.sv
module nes_clk_chk (
    input logic                    clk_ppu,
    input logic                    rst_ppu,
    input nes_clk_pkg::cpu_phase_t cpu_phase,
    input logic                    cpu_en,
    input logic                    rst_cpu,
    input nes_clk_pkg::dot_t       dot,
    input nes_clk_pkg::scanline_t  scanline,
    input logic                    vblank,
    input logic                    full,
    input nes_clk_pkg::reg_data_t  ppu_ctrl,
    input logic                    nmi
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_N = nes_clk_pkg::RST_CPU_CYCLES;
    localparam nes_clk_pkg::scanline_t SET_LINE =
        nes_clk_pkg::scanline_t'(nes_clk_pkg::VBLANK_LINE);
    localparam nes_clk_pkg::scanline_t CLR_LINE =
        nes_clk_pkg::scanline_t'(nes_clk_pkg::PRERENDER_LINE);

    int fail_count = 0;   // failed assertions so far
    nes_clk_pkg::cpu_phase_t phase_step;
    logic at_flag_dot;

    assign phase_step  = (cpu_phase == 2'd2) ? 2'd0 : cpu_phase + 2'd1;
    assign at_flag_dot = (dot == nes_clk_pkg::dot_t'(nes_clk_pkg::VBLANK_DOT));

    reset_state: assert property (@(posedge clk_ppu) rst_ppu |=>
        (cpu_phase == 2'd0 && !cpu_en && rst_cpu && !vblank && !nmi && dot == '0))
        else begin
            $error("reset state wrong");
            fail_count++;
        end
    phase_steps: assert property (@(posedge clk_ppu) !rst_ppu |=> cpu_phase == $past(phase_step))
        else begin
            $error("cpu_phase did not step 0 1 2");
            fail_count++;
        end
    en_decode: assert property (@(posedge clk_ppu) cpu_en == (cpu_phase == 2'd2))
        else begin
            $error("cpu_en not high exactly at phase 2");
            fail_count++;
        end
    cpu_release: assert property (@(posedge clk_ppu)
        $fell(rst_ppu) |-> rst_cpu ##(RST_N - 1) rst_cpu ##1 !rst_cpu)
        else begin
            $error("rst_cpu did not fall on the eighth edge");
            fail_count++;
        end
    never_full: assert property (@(posedge clk_ppu) disable iff (rst_ppu) !full)
        else begin
            $error("write fifo reached full");
            fail_count++;
        end
    vblank_pos: assert property (@(posedge clk_ppu) disable iff (rst_ppu)
        $changed(vblank) |-> at_flag_dot && scanline == (vblank ? SET_LINE : CLR_LINE))
        else begin
            $error("vblank changed at the wrong position");
            fail_count++;
        end
    nmi_level: assert property (@(posedge clk_ppu) nmi == (vblank && ppu_ctrl[7]))
        else begin
            $error("nmi is not vblank and ctrl bit 7");
            fail_count++;
        end

endmodule

bind nes_clk_top nes_clk_chk chk (.*);

// File: dv/nes_clk_tb.sv
module nes_clk_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam longint FRAME_NS = longint'(nes_clk_pkg::DOTS_PER_LINE)
        * nes_clk_pkg::LINES_PER_FRAME * CLK_PERIOD;

    logic clk_ppu, rst_ppu, cpu_wr;
    nes_clk_pkg::reg_addr_t  cpu_addr;
    nes_clk_pkg::reg_data_t  cpu_wdata;
    nes_clk_pkg::cpu_phase_t cpu_phase;
    logic cpu_en, rst_cpu, vblank, full, nmi;
    nes_clk_pkg::dot_t       dot;
    nes_clk_pkg::scanline_t  scanline;
    nes_clk_pkg::reg_data_t  ppu_ctrl, ppu_mask, oam_addr, scroll_x, scroll_y;
    nes_clk_pkg::vram_addr_t vram_addr;

    // expected register state
    nes_clk_pkg::reg_data_t  ref_ctrl, ref_mask, ref_oam, ref_sx, ref_sy;
    nes_clk_pkg::vram_addr_t ref_vram;
    logic ref_second;       // shared scroll/address toggle
    integer seed;
    int errors, tests, test_base;

    nes_clk_top dut (.*);

    initial begin
        clk_ppu = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_ppu = ~clk_ppu;
        end
    end

    initial begin
        #(2 * FRAME_NS * 11 / 10);
        $display("watchdog timeout, run did not finish within two frames");
        $display("Test FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_regs();
        check_value("ppu_ctrl", ppu_ctrl, ref_ctrl);
        check_value("ppu_mask", ppu_mask, ref_mask);
        check_value("oam_addr", oam_addr, ref_oam);
        check_value("scroll_x", scroll_x, ref_sx);
        check_value("scroll_y", scroll_y, ref_sy);
        check_value("vram_addr", vram_addr, ref_vram);
        check_value("nmi", nmi, vblank & ref_ctrl[7]);
    endtask

    function automatic void apply_ref(input nes_clk_pkg::reg_addr_t a,
                                      input nes_clk_pkg::reg_data_t d);
        case (a)
            nes_clk_pkg::REG_CTRL:    ref_ctrl = d;
            nes_clk_pkg::REG_MASK:    ref_mask = d;
            nes_clk_pkg::REG_OAMADDR: ref_oam = d;
            nes_clk_pkg::REG_SCROLL: begin
                if (ref_second) ref_sy = d;
                else ref_sx = d;
                ref_second = !ref_second;
            end
            nes_clk_pkg::REG_ADDR: begin
                if (ref_second) ref_vram[7:0] = d;
                else ref_vram[13:8] = d[5:0];
                ref_second = !ref_second;
            end
            default: ;
        endcase
    endfunction

    // starts and ends on a falling edge
    task automatic cpu_write(input nes_clk_pkg::reg_addr_t a, input nes_clk_pkg::reg_data_t d);
        while (!cpu_en) @(negedge clk_ppu);
        cpu_wr    = 1'b1;
        cpu_addr  = a;
        cpu_wdata = d;
        @(negedge clk_ppu);     // accepted
        cpu_wr = 1'b0;
        check_regs();
        @(negedge clk_ppu);     // sitting in the fifo
        check_regs();
        apply_ref(a, d);
        @(negedge clk_ppu);
        check_regs();
    endtask

    task automatic wait_vblank(input logic level);
        while (vblank != level) @(negedge clk_ppu);
    endtask

    task automatic finish_test(input string name);
        int fails;
        fails = errors + dut.chk.fail_count - test_base;
        tests++;
        $display("test %0d %s: %s", tests, name, (fails == 0) ? "passed" : "failed");
        test_base = errors + dut.chk.fail_count;
    endtask

    initial begin
        int edges;
        logic [31:0] r;
        seed      = 32'hd018ff88;
        rst_ppu   = 1'b1;
        cpu_wr    = 1'b0;
        cpu_addr  = 3'd0;
        cpu_wdata = 8'd0;
        ref_ctrl   = '0;
        ref_mask   = '0;
        ref_oam    = '0;
        ref_sx     = '0;
        ref_sy     = '0;
        ref_vram   = '0;
        ref_second = 1'b0;
        errors    = 0;
        tests     = 0;
        test_base = 0;
        repeat (8) @(posedge clk_ppu);
        @(negedge clk_ppu);
        rst_ppu = 1'b0;
        // a write held through the cpu reset stretch must be dropped
        cpu_wr    = 1'b1;
        cpu_addr  = nes_clk_pkg::REG_CTRL;
        cpu_wdata = 8'hff;
        edges = 0;
        while (rst_cpu) begin
            @(negedge clk_ppu);
            edges++;
        end
        cpu_wr = 1'b0;
        check_value("rst_cpu release edge", edges, nes_clk_pkg::RST_CPU_CYCLES);
        finish_test("clock enables and cpu reset");

        for (int i = 0; i < 12; i++) begin
            cpu_wr    = !cpu_en;
            cpu_addr  = nes_clk_pkg::reg_addr_t'($random(seed));
            cpu_wdata = nes_clk_pkg::reg_data_t'($random(seed));
            @(negedge clk_ppu);
        end
        cpu_wr = 1'b0;
        repeat (3) @(negedge clk_ppu);
        check_regs();
        finish_test("ignored writes");

        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    cpu_write(nes_clk_pkg::REG_CTRL, r[15:8]);
                2'd1:    cpu_write(nes_clk_pkg::REG_MASK, r[15:8]);
                default: cpu_write(nes_clk_pkg::REG_OAMADDR, r[15:8]);
            endcase
        end
        finish_test("control mask oam writes");

        cpu_write(nes_clk_pkg::REG_SCROLL, 8'h3c);
        cpu_write(nes_clk_pkg::REG_SCROLL, 8'hc3);
        cpu_write(nes_clk_pkg::REG_ADDR, 8'hff);   // top bits fall away
        cpu_write(nes_clk_pkg::REG_ADDR, 8'h5a);
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    cpu_write(nes_clk_pkg::REG_MASK, r[15:8]);
                2'd1:    cpu_write(nes_clk_pkg::REG_ADDR, r[15:8]);
                default: cpu_write(nes_clk_pkg::REG_SCROLL, r[15:8]);
            endcase
        end
        finish_test("scroll and address toggle");

        cpu_write(nes_clk_pkg::REG_CTRL, 8'h00);
        wait_vblank(1'b1);
        check_value("scanline", scanline, nes_clk_pkg::VBLANK_LINE);
        check_value("dot", dot, nes_clk_pkg::VBLANK_DOT);
        check_value("nmi", nmi, 0);
        cpu_write(nes_clk_pkg::REG_CTRL, nes_clk_pkg::reg_data_t'($random(seed)) | 8'h80);
        check_value("nmi", nmi, 1);
        wait_vblank(1'b0);
        check_value("scanline", scanline, nes_clk_pkg::PRERENDER_LINE);
        check_value("dot", dot, nes_clk_pkg::VBLANK_DOT);
        check_value("nmi", nmi, 0);
        wait_vblank(1'b1);
        check_value("nmi", nmi, 1);
        finish_test("vblank and nmi");

        $display("tests %0d, check errors %0d, assertion failures %0d",
                 tests, errors, dut.chk.fail_count);
        if (errors + dut.chk.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: nes_clk_core.f
hdl/nes_clk_pkg.sv
hdl/clock_enables.sv
hdl/ppu_timing.sv
hdl/cpu_write_port.sv
hdl/reg_write_fifo.sv
hdl/ppu_reg_file.sv
hdl/nes_clk_top.sv
dv/nes_clk_chk.sv
dv/nes_clk_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := nes_clk_tb
FILELIST   := nes_clk_core.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
SIM        := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
